//--- bpu_frontend.f
+incdir+testbench
hw/bpu_pkg.sv
hw/bpu_regfile.sv
hw/bpu_train.sv
hw/bpu.sv
hw/fetch_pc_gen.sv
hw/bpu_frontend.sv
testbench/bpu_frontend_tb.sv

//--- testbench/bpu_frontend_tb_tasks.svh
`ifndef BPU_FRONTEND_TB_TASKS_SVH
`define BPU_FRONTEND_TB_TASKS_SVH

int errors = 0;
int checks = 0;

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
   checks++;
   assert (got === exp)
   else
   begin
      errors++;
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
   end
endtask

// Returns at the falling edge where the next live block shows
task automatic next_block(output logic [PC_W-1:0] base);
   @(negedge clk);
   while (!out_valid)
      @(negedge clk);
   base = out_pc[PC_W-1:0];
endtask

// One writeback pulse, fields taken from the reference tables
task automatic send_writeback(input logic [PC_W-1:0] bpc, input logic [PC_W-1:0] tgt,
                              input logic tk, input logic bcc, input logic mode);
   logic [PHT_AW-1:0] pidx;
   pidx = bpc[2 +: PHT_AW] ^ ref_ghsr;
   wb_pc = bpc;
   wb_mode = mode;
   bpu_wb = 1'b1;
   bpu_wb_is_bcc = bcc;
   bpu_wb_is_breg = 1'b0;
   bpu_wb_is_brel = 1'b1;
   bpu_wb_taken = tk;
   bpu_wb_pc_tag = bpc[PC_W-1 -: BTB_TAG_W];
   bpu_wb_npc_act = tgt;
   bpu_wb_upd_partial = '0;
   bpu_wb_upd_partial[UPD_COUNT_LSB +: PHT_DW] = ref_pht[pidx];
   bpu_wb_upd_partial[UPD_PHT_ADDR_LSB +: PHT_AW] = pidx;
   bpu_wb_upd_partial[UPD_BTB_ADDR_LSB +: BTB_AW] = bpc[2 +: BTB_AW];
   bpu_wb_upd_partial[UPD_IMME_LSB] = mode;
   @(negedge clk);
   bpu_wb = 1'b0;
endtask

task automatic redirect_to(input logic [PC_W-1:0] target);
   redirect = 1'b1;
   redirect_pc = target;
   @(negedge clk);
   redirect = 1'b0;
endtask

// Stage 2 must freeze while stalled, then the stream resumes in order
task automatic hold_stall(input int n);
   logic [PC_W-1:0] held;
   logic [PC_W-1:0] base;
   held = out_pc[PC_W-1:0];
   stall = 1'b1;
   repeat (n)
   begin
      @(negedge clk);
      check_value(out_valid, 1'b0, "out_valid under stall");
      check_value(out_pc[PC_W-1:0], held, "out_pc under stall");
   end
   stall = 1'b0;
   for (int k = 1; k <= 3; k++)
   begin
      next_block(base);
      check_value(base, held + k * FETCH_BYTES, "block after stall");
   end
endtask

`endif

//--- testbench/bpu_frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_frontend_tb
   import bpu_pkg::*;
();

   localparam int PHT_N = 1 << PHT_AW;
   localparam int BTB_N = 1 << BTB_AW;
   // Far above what the stimulus needs
   localparam int MAX_CYCLES = 4000;

   logic                           clk;
   logic                           rst;
   logic                           stall;
   logic                           imme;
   logic                           redirect;
   logic [PC_W-1:0]                redirect_pc;
   logic                           bpu_wb;
   logic                           bpu_wb_is_bcc;
   logic                           bpu_wb_is_breg;
   logic                           bpu_wb_is_brel;
   logic                           bpu_wb_taken;
   logic [BTB_TAG_W-1:0]           bpu_wb_pc_tag;
   logic [PC_W-1:0]                bpu_wb_npc_act;
   logic [UPD_W-1:UPD_TAKEN_TGT_W] bpu_wb_upd_partial;
   logic                           out_valid;
   logic [PC_W*FETCH_N-1:0]        out_pc;
   logic [FETCH_N-1:0]             out_taken;
   logic [PC_W*FETCH_N-1:0]        out_npc;
   logic [UPD_W*FETCH_N-1:0]       out_upd;

   logic [PC_W-1:0] wb_pc;
   logic            wb_mode;
   logic [31:0]     lfsr = 32'hff50_4890;
   int              cycle_count = 0;

   // Reference tables and their copy from the last capture edge
   logic [PHT_DW-1:0]    ref_pht [0:PHT_N-1];
   logic                 ref_v [0:BTB_N-1];
   logic                 ref_bcc [0:BTB_N-1];
   logic [BTB_TAG_W-1:0] ref_tag [0:BTB_N-1];
   logic [PC_W-1:0]      ref_tgt [0:BTB_N-1];
   logic                 ref_mode [0:BTB_N-1];
   logic [PHT_AW-1:0]    ref_ghsr;
   logic [PHT_DW-1:0]    cap_pht [0:PHT_N-1];
   logic                 cap_v [0:BTB_N-1];
   logic                 cap_bcc [0:BTB_N-1];
   logic [BTB_TAG_W-1:0] cap_tag [0:BTB_N-1];
   logic [PC_W-1:0]      cap_tgt [0:BTB_N-1];
   logic                 cap_mode [0:BTB_N-1];
   logic [PHT_AW-1:0]    cap_ghsr;
   logic                 cap_imme;

`include "bpu_frontend_tb_tasks.svh"

   bpu_frontend DUT (
      .clk                (clk),
      .rst                (rst),
      .stall              (stall),
      .imme               (imme),
      .redirect           (redirect),
      .redirect_pc        (redirect_pc),
      .bpu_wb             (bpu_wb),
      .bpu_wb_is_bcc      (bpu_wb_is_bcc),
      .bpu_wb_is_breg     (bpu_wb_is_breg),
      .bpu_wb_is_brel     (bpu_wb_is_brel),
      .bpu_wb_taken       (bpu_wb_taken),
      .bpu_wb_pc_tag      (bpu_wb_pc_tag),
      .bpu_wb_npc_act     (bpu_wb_npc_act),
      .bpu_wb_upd_partial (bpu_wb_upd_partial),
      .out_valid          (out_valid),
      .out_pc             (out_pc),
      .out_taken          (out_taken),
      .out_npc            (out_npc),
      .out_upd            (out_upd)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   // Expected prediction for the block in stage 2
   task automatic check_prediction();
      logic [PC_W-1:0]   spc;
      logic [PHT_AW-1:0] pidx;
      logic [BTB_AW-1:0] bidx;
      logic              exp_tk;
      for (int i = 0; i < FETCH_N; i++)
      begin
         spc = out_pc[i*PC_W +: PC_W];
         pidx = spc[2 +: PHT_AW] ^ cap_ghsr;
         bidx = spc[2 +: BTB_AW];
         exp_tk = cap_v[bidx] && cap_tag[bidx] == spc[PC_W-1 -: BTB_TAG_W]
                  && cap_mode[bidx] == cap_imme && (!cap_bcc[bidx] || cap_pht[pidx][1]);
         check_value(out_taken[i], exp_tk, "slot taken flag");
         check_value(out_upd[i*UPD_W + UPD_COUNT_LSB +: PHT_DW], cap_pht[pidx], "upd count");
         check_value(out_upd[i*UPD_W + UPD_PHT_ADDR_LSB +: PHT_AW], pidx, "upd PHT index");
         check_value(out_upd[i*UPD_W + UPD_BTB_ADDR_LSB +: BTB_AW], bidx, "upd BTB index");
         check_value(out_upd[i*UPD_W + UPD_IMME_LSB], cap_imme, "upd mode bit");
         check_value(out_upd[i*UPD_W + UPD_TAKEN_LSB], exp_tk, "upd taken bit");
         if (exp_tk)
         begin
            check_value(out_npc[i*PC_W +: PC_W], cap_tgt[bidx], "predicted target");
            check_value(out_upd[i*UPD_W + UPD_TGT_LSB +: PC_W], cap_tgt[bidx],
                        "upd target");
         end
      end
   endtask

   task automatic apply_writeback();
      logic [PHT_AW-1:0] pidx;
      logic [BTB_AW-1:0] bidx;
      pidx = wb_pc[2 +: PHT_AW] ^ ref_ghsr;
      bidx = wb_pc[2 +: BTB_AW];
      if (bpu_wb_is_bcc)
      begin
         if (bpu_wb_taken)
            ref_pht[pidx] = (ref_pht[pidx] == 2'd3) ? 2'd3 : ref_pht[pidx] + 2'd1;
         else
            ref_pht[pidx] = (ref_pht[pidx] == 2'd0) ? 2'd0 : ref_pht[pidx] - 2'd1;
         ref_ghsr = {ref_ghsr[PHT_AW-2:0], bpu_wb_taken};
      end
      if (bpu_wb_is_breg || bpu_wb_is_brel)
      begin
         ref_v[bidx] = 1'b1;
         ref_bcc[bidx] = bpu_wb_is_bcc;
         ref_tag[bidx] = wb_pc[PC_W-1 -: BTB_TAG_W];
         ref_tgt[bidx] = bpu_wb_npc_act;
         ref_mode[bidx] = wb_mode;
      end
   endtask

   // Same-edge reads see old data so the copy comes before training
   always @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < PHT_N; i++)
            ref_pht[i] = '0;
         for (int i = 0; i < BTB_N; i++)
         begin
            ref_v[i] = 1'b0;
            ref_bcc[i] = 1'b0;
            ref_tag[i] = '0;
            ref_tgt[i] = '0;
            ref_mode[i] = 1'b0;
         end
         ref_ghsr = '0;
      end
      else
      begin
         if (out_valid)
            check_prediction();
         if (!stall)
         begin
            cap_pht = ref_pht;
            cap_v = ref_v;
            cap_bcc = ref_bcc;
            cap_tag = ref_tag;
            cap_tgt = ref_tgt;
            cap_mode = ref_mode;
            cap_ghsr = ref_ghsr;
            cap_imme = imme;
         end
         if (bpu_wb)
            apply_writeback();
      end
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES)
      begin
         $display("Run stopped after %0d cycles before the tests finished", cycle_count);
         $display("Simulation failed");
         $finish;
      end
   end

   initial
   begin : stimulus
      logic [PC_W-1:0] base;
      logic [PC_W-1:0] br_pc;
      logic [PC_W-1:0] br_tgt;
      logic [PC_W-1:0] bcc_pc;
      logic [PC_W-1:0] bcc_tgt;
      logic [PC_W-1:0] far_pc;
      rst = 1'b1;
      stall = 1'b0;
      imme = 1'b0;
      redirect = 1'b0;
      redirect_pc = '0;
      bpu_wb = 1'b0;
      bpu_wb_is_bcc = 1'b0;
      bpu_wb_is_breg = 1'b0;
      bpu_wb_is_brel = 1'b0;
      bpu_wb_taken = 1'b0;
      bpu_wb_pc_tag = '0;
      bpu_wb_npc_act = '0;
      bpu_wb_upd_partial = '0;
      wb_pc = '0;
      wb_mode = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Untrained sequential stream from the reset vector
      for (int k = 0; k < 6; k++)
      begin
         next_block(base);
         check_value(base, RESET_PC + k * FETCH_BYTES, "sequential block base");
         check_value(out_taken, '0, "taken flags before training");
      end

      // Relative branch in the lower half of the BTB
      br_pc = 32'h0000_2000 | (lfsr_bits(5) << 2);
      br_tgt = 32'h0004_0000 | (lfsr_bits(12) << 3);
      send_writeback(br_pc, br_tgt, 1'b1, 1'b0, 1'b0);
      redirect_to(br_pc & ~32'h7);
      next_block(base);
      check_value(base, br_pc & ~32'h7, "block holding the branch");
      check_value(out_taken[br_pc[2]], 1'b1, "trained slot taken");
      check_value(out_npc[br_pc[2]*PC_W +: PC_W], br_tgt, "trained slot target");
      next_block(base);
      check_value(base, br_tgt, "block after taken branch");

      // Other mode bit misses the entry
      imme = 1'b1;
      redirect_to(br_pc & ~32'h7);
      next_block(base);
      check_value(base, br_pc & ~32'h7, "block under other mode");
      check_value(out_taken, '0, "taken flags under other mode");
      next_block(base);
      check_value(base, (br_pc & ~32'h7) + FETCH_BYTES, "sequential after mode miss");
      imme = 1'b0;

      // Redirect lands while the taken block sits in stage 2
      redirect_to(br_pc & ~32'h7);
      next_block(base);
      check_value(out_taken[br_pc[2]], 1'b1, "taken before redirect");
      far_pc = 32'h0008_0000 | (lfsr_bits(10) << 3);
      redirect_to(far_pc);
      next_block(base);
      check_value(base, far_pc, "redirect over prediction");

      hold_stall(5);

      // Conditional branch trained with mostly taken LFSR outcomes
      bcc_pc = 32'h0000_3080 | (lfsr_bits(5) << 2);
      bcc_tgt = 32'h0006_0000 | (lfsr_bits(12) << 3);
      for (int k = 0; k < 16; k++)
      begin
         redirect_to(bcc_pc & ~32'h7);
         next_block(base);
         check_value(base, bcc_pc & ~32'h7, "conditional branch block");
         send_writeback(bcc_pc, bcc_tgt, lfsr_bits(2) != 0, 1'b1, 1'b0);
      end
      repeat (4) @(negedge clk);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/bpu_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_frontend
   import bpu_pkg::*;
(
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             stall,
   input  logic                             imme,
   input  logic                             redirect,
   input  logic [PC_W-1:0]                  redirect_pc,
   input  logic                             bpu_wb,
   input  logic                             bpu_wb_is_bcc,
   input  logic                             bpu_wb_is_breg,
   input  logic                             bpu_wb_is_brel,
   input  logic                             bpu_wb_taken,
   input  logic [BTB_TAG_W-1:0]             bpu_wb_pc_tag,
   input  logic [PC_W-1:0]                  bpu_wb_npc_act,
   input  logic [UPD_W-1:UPD_TAKEN_TGT_W]   bpu_wb_upd_partial,
   output logic                             out_valid,
   output logic [PC_W*FETCH_N-1:0]          out_pc,
   output logic [FETCH_N-1:0]               out_taken,
   output logic [PC_W*FETCH_N-1:0]          out_npc,
   output logic [UPD_W*FETCH_N-1:0]         out_upd
);

   logic                    re;
   logic [PC_W*FETCH_N-1:0] fetch_pc;
   logic [FETCH_N-1:0]      fetch_valid;
   logic                    s2_valid;

   // Slot addresses of the block now in stage 2
   always_ff @(posedge clk)
   begin
      if (re)
      begin
         out_pc <= fetch_pc;
      end
   end

   fetch_pc_gen u_pc_gen (
      .clk         (clk),
      .rst         (rst),
      .stall       (stall),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .pred_taken  (out_taken),
      .pred_npc    (out_npc),
      .s2_valid    (s2_valid),
      .re          (re),
      .pc          (fetch_pc),
      .valid       (fetch_valid),
      .out_valid   (out_valid)
   );

   bpu u_bpu (
      .clk                (clk),
      .rst                (rst),
      .re                 (re),
      .valid              (fetch_valid),
      .imme               (imme),
      .pc                 (fetch_pc),
      .npc                (out_npc),
      .taken              (out_taken),
      .upd                (out_upd),
      .s2_valid           (s2_valid),
      .bpu_wb             (bpu_wb),
      .bpu_wb_is_bcc      (bpu_wb_is_bcc),
      .bpu_wb_is_breg     (bpu_wb_is_breg),
      .bpu_wb_is_brel     (bpu_wb_is_brel),
      .bpu_wb_taken       (bpu_wb_taken),
      .bpu_wb_pc_tag      (bpu_wb_pc_tag),
      .bpu_wb_npc_act     (bpu_wb_npc_act),
      .bpu_wb_upd_partial (bpu_wb_upd_partial)
   );

endmodule

`default_nettype wire

//--- hw/fetch_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen
   import bpu_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    stall,
   input  logic                    redirect,
   input  logic [PC_W-1:0]         redirect_pc,
   input  logic [FETCH_N-1:0]      pred_taken,
   input  logic [PC_W*FETCH_N-1:0] pred_npc,
   input  logic                    s2_valid,
   output logic                    re,
   output logic [PC_W*FETCH_N-1:0] pc,
   output logic [FETCH_N-1:0]      valid,
   output logic                    out_valid
);

   logic [PC_W-1:0] fetch_pc;
   logic [PC_W-1:0] fetch_pc_nxt;
   logic [PC_W-1:0] block_base;
   logic [PC_W-1:0] pred_pc;
   logic            pred_follow;
   logic            squash;

   assign re = ~stall;

   // Aligned block base, slots below the entry word are masked off
   assign block_base = {fetch_pc[PC_W-1:FETCH_OFS_W], {FETCH_OFS_W{1'b0}}};

   for (genvar i = 0; i < FETCH_N; i++)
   begin : g_slot
      assign pc[i*PC_W +: PC_W] = block_base + PC_W'(i * INSN_BYTES);
      assign valid[i] = (fetch_pc[FETCH_OFS_W-1:INSN_OFS_W] <= SLOT_W'(i));
   end

   // Lowest taken slot wins
   always_comb
   begin
      pred_pc = pred_npc[PC_W-1:0];
      for (int i = FETCH_N - 1; i >= 0; i--)
      begin
         if (pred_taken[i])
         begin
            pred_pc = pred_npc[i*PC_W +: PC_W];
         end
      end
   end

   // A squashed stage-2 block must not steer fetch
   assign pred_follow = s2_valid & ~squash & (|pred_taken);
   assign out_valid   = s2_valid & ~squash;

   always_comb
   begin
      if (redirect)
         fetch_pc_nxt = redirect_pc;
      else if (pred_follow)
         fetch_pc_nxt = pred_pc;
      else if (re)
         fetch_pc_nxt = block_base + PC_W'(FETCH_BYTES);
      else
         fetch_pc_nxt = fetch_pc;
   end

   // Squash rides with the block captured on the same edge
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         fetch_pc <= RESET_PC;
         squash   <= 1'b0;
      end
      else
      begin
         fetch_pc <= fetch_pc_nxt;
         if (re)
         begin
            squash <= redirect | pred_follow;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/bpu.sv
`timescale 1ns/1ps
`default_nettype none

module bpu
   import bpu_pkg::*;
(
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             re,
   input  logic [FETCH_N-1:0]               valid,
   input  logic                             imme,
   input  logic [PC_W*FETCH_N-1:0]          pc,
   output logic [PC_W*FETCH_N-1:0]          npc,
   output logic [FETCH_N-1:0]               taken,
   output logic [UPD_W*FETCH_N-1:0]         upd,
   output logic                             s2_valid,
   input  logic                             bpu_wb,
   input  logic                             bpu_wb_is_bcc,
   input  logic                             bpu_wb_is_breg,
   input  logic                             bpu_wb_is_brel,
   input  logic                             bpu_wb_taken,
   input  logic [BTB_TAG_W-1:0]             bpu_wb_pc_tag,
   input  logic [PC_W-1:0]                  bpu_wb_npc_act,
   input  logic [UPD_W-1:UPD_TAKEN_TGT_W]   bpu_wb_upd_partial
);

   logic [PHT_AW*FETCH_N-1:0] s1_pht_addr;
   logic [BTB_AW*FETCH_N-1:0] s1_btb_addr;
   logic [PC_W*FETCH_N-1:0]   s2_pc;
   logic [PHT_AW*FETCH_N-1:0] s2_pht_addr;
   logic [BTB_AW*FETCH_N-1:0] s2_btb_addr;
   logic [FETCH_N-1:0]        s2_slot_valid;
   logic                      s2_imme;
   logic [PHT_DW*FETCH_N-1:0] pht_rdata;
   logic [BTB_DW*FETCH_N-1:0] btb_rdata;
   logic                      pht_we;
   logic [PHT_AW-1:0]         pht_waddr;
   logic [PHT_DW-1:0]         pht_wdata;
   logic                      btb_we;
   logic [BTB_AW-1:0]         btb_waddr;
   logic [BTB_DW-1:0]         btb_wdata;
   logic [PHT_AW-1:0]         ghsr;

   for (genvar i = 0; i < FETCH_N; i++)
   begin : g_slot
      logic [PC_W-1:0]      slot_pc;
      logic [PHT_DW-1:0]    count;
      logic                 btb_v;
      logic                 btb_is_bcc;
      logic [BTB_TAG_W-1:0] btb_tag;
      logic [PC_W-1:0]      btb_npc;
      logic                 btb_imme;
      logic                 btb_hit;

      // Stage 1 index hash on the word address
      assign slot_pc = pc[i*PC_W +: PC_W];
      assign s1_pht_addr[i*PHT_AW +: PHT_AW] = slot_pc[INSN_OFS_W +: PHT_AW] ^ ghsr;
      assign s1_btb_addr[i*BTB_AW +: BTB_AW] = slot_pc[INSN_OFS_W +: BTB_AW];

      // Stage 2 lookup result
      assign count = pht_rdata[i*PHT_DW +: PHT_DW];
      assign {btb_imme, btb_npc, btb_tag, btb_is_bcc, btb_v} = btb_rdata[i*BTB_DW +: BTB_DW];

      assign btb_hit = btb_v
                     & (btb_tag == s2_pc[i*PC_W + BTB_AW + INSN_OFS_W +: BTB_TAG_W])
                     & (btb_imme == s2_imme);

      // Unconditional hits always go, conditional ones follow the counter MSB
      assign taken[i] = s2_slot_valid[i] & btb_hit & (~btb_is_bcc | count[PHT_DW-1]);
      assign npc[i*PC_W +: PC_W] = btb_npc;

      assign upd[i*UPD_W + UPD_COUNT_LSB +: PHT_DW]    = count;
      assign upd[i*UPD_W + UPD_PHT_ADDR_LSB +: PHT_AW] = s2_pht_addr[i*PHT_AW +: PHT_AW];
      assign upd[i*UPD_W + UPD_BTB_ADDR_LSB +: BTB_AW] = s2_btb_addr[i*BTB_AW +: BTB_AW];
      assign upd[i*UPD_W + UPD_IMME_LSB]               = s2_imme;
      assign upd[i*UPD_W + UPD_TGT_LSB +: PC_W]        = btb_npc;
      assign upd[i*UPD_W + UPD_TAKEN_LSB]              = taken[i];
   end

   // s2_valid marks a block freshly captured on the last edge
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         s2_valid      <= 1'b0;
         s2_slot_valid <= '0;
         s2_imme       <= 1'b0;
      end
      else
      begin
         s2_valid <= re;
         if (re)
         begin
            s2_slot_valid <= valid;
            s2_imme       <= imme;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (re)
      begin
         s2_pc       <= pc;
         s2_pht_addr <= s1_pht_addr;
         s2_btb_addr <= s1_btb_addr;
      end
   end

   bpu_regfile #(
      .DW       (PHT_DW),
      .AW       (PHT_AW),
      .NUM_READ (FETCH_N)
   ) u_pht (
      .clk   (clk),
      .rst   (rst),
      .re    (re),
      .raddr (s1_pht_addr),
      .we    (pht_we),
      .waddr (pht_waddr),
      .wdata (pht_wdata),
      .rdata (pht_rdata)
   );

   bpu_regfile #(
      .DW       (BTB_DW),
      .AW       (BTB_AW),
      .NUM_READ (FETCH_N)
   ) u_btb (
      .clk   (clk),
      .rst   (rst),
      .re    (re),
      .raddr (s1_btb_addr),
      .we    (btb_we),
      .waddr (btb_waddr),
      .wdata (btb_wdata),
      .rdata (btb_rdata)
   );

   bpu_train u_train (
      .clk            (clk),
      .rst            (rst),
      .wb             (bpu_wb),
      .wb_is_bcc      (bpu_wb_is_bcc),
      .wb_is_breg     (bpu_wb_is_breg),
      .wb_is_brel     (bpu_wb_is_brel),
      .wb_taken       (bpu_wb_taken),
      .wb_pc_tag      (bpu_wb_pc_tag),
      .wb_npc_act     (bpu_wb_npc_act),
      .wb_upd_partial (bpu_wb_upd_partial),
      .pht_we         (pht_we),
      .pht_waddr      (pht_waddr),
      .pht_wdata      (pht_wdata),
      .btb_we         (btb_we),
      .btb_waddr      (btb_waddr),
      .btb_wdata      (btb_wdata),
      .ghsr           (ghsr)
   );

endmodule

`default_nettype wire

//--- hw/bpu_train.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_train
   import bpu_pkg::*;
(
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             wb,
   input  logic                             wb_is_bcc,
   input  logic                             wb_is_breg,
   input  logic                             wb_is_brel,
   input  logic                             wb_taken,
   input  logic [BTB_TAG_W-1:0]             wb_pc_tag,
   input  logic [PC_W-1:0]                  wb_npc_act,
   input  logic [UPD_W-1:UPD_TAKEN_TGT_W]   wb_upd_partial,
   output logic                             pht_we,
   output logic [PHT_AW-1:0]                pht_waddr,
   output logic [PHT_DW-1:0]                pht_wdata,
   output logic                             btb_we,
   output logic [BTB_AW-1:0]                btb_waddr,
   output logic [BTB_DW-1:0]                btb_wdata,
   output logic [PHT_AW-1:0]                ghsr
);

   logic [PHT_DW-1:0] count_org;
   logic              wb_imme;

   // Fields recorded at prediction time
   assign count_org = wb_upd_partial[UPD_COUNT_LSB +: PHT_DW];
   assign pht_waddr = wb_upd_partial[UPD_PHT_ADDR_LSB +: PHT_AW];
   assign btb_waddr = wb_upd_partial[UPD_BTB_ADDR_LSB +: BTB_AW];
   assign wb_imme   = wb_upd_partial[UPD_IMME_LSB];

   assign pht_we = wb & wb_is_bcc;
   assign btb_we = wb & (wb_is_breg | wb_is_brel);

   // Two-bit saturating counter step
   always_comb
   begin
      if (wb_taken)
      begin
         pht_wdata = (count_org == '1) ? count_org : count_org + 1'b1;
      end
      else
      begin
         pht_wdata = (count_org == '0) ? count_org : count_org - 1'b1;
      end
   end

   // New entry is always marked valid
   assign btb_wdata = {wb_imme, wb_npc_act, wb_pc_tag, wb_is_bcc, 1'b1};

   // Global history, one bit per conditional branch resolved
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ghsr <= '0;
      end
      else if (pht_we)
      begin
         ghsr <= {ghsr[PHT_AW-2:0], wb_taken};
      end
   end

endmodule

`default_nettype wire

//--- hw/bpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_regfile
#(
   parameter int DW       = 8,
   parameter int AW       = 4,
   parameter int NUM_READ = 2
)
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   re,
   input  logic [NUM_READ*AW-1:0] raddr,
   input  logic                   we,
   input  logic [AW-1:0]          waddr,
   input  logic [DW-1:0]          wdata,
   output logic [NUM_READ*DW-1:0] rdata
);

   logic [DW-1:0] mem [0:(1<<AW)-1];

   // Single write port, table starts out all zero
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < (1 << AW); i++)
         begin
            mem[i] <= '0;
         end
      end
      else if (we)
      begin
         mem[waddr] <= wdata;
      end
   end

   // Registered read ports, old contents on a same-edge write
   for (genvar p = 0; p < NUM_READ; p++)
   begin : g_rd
      always_ff @(posedge clk)
      begin
         if (rst)
         begin
            rdata[p*DW +: DW] <= '0;
         end
         else if (re)
         begin
            rdata[p*DW +: DW] <= mem[raddr[p*AW +: AW]];
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

   // Address and fetch block geometry
   localparam int PC_W        = 32;
   localparam int FETCH_N     = 2;
   localparam int INSN_BYTES  = 4;
   localparam int INSN_OFS_W  = $clog2(INSN_BYTES);
   localparam int SLOT_W      = $clog2(FETCH_N);
   localparam int FETCH_BYTES = FETCH_N * INSN_BYTES;
   localparam int FETCH_OFS_W = INSN_OFS_W + SLOT_W;

   // Pattern history table, also sets the global history length
   localparam int PHT_AW = 8;
   localparam int PHT_DW = 2;

   // Branch target buffer
   localparam int BTB_AW    = 6;
   localparam int BTB_TAG_W = PC_W - BTB_AW - INSN_OFS_W;
   // Entry is {imme, target, tag, is_bcc, valid}
   localparam int BTB_DW    = 1 + PC_W + BTB_TAG_W + 1 + 1;

   // Per-slot update word, MSB first: {count, pht_addr, btb_addr, imme, target, taken}
   localparam int UPD_W = PHT_DW + PHT_AW + BTB_AW + 1 + PC_W + 1;

   // Low part that writeback does not hand back
   localparam int UPD_TAKEN_TGT_W = PC_W + 1;

   localparam int UPD_TAKEN_LSB    = 0;
   localparam int UPD_TGT_LSB      = UPD_TAKEN_LSB + 1;
   localparam int UPD_IMME_LSB     = UPD_TGT_LSB + PC_W;
   localparam int UPD_BTB_ADDR_LSB = UPD_IMME_LSB + 1;
   localparam int UPD_PHT_ADDR_LSB = UPD_BTB_ADDR_LSB + BTB_AW;
   localparam int UPD_COUNT_LSB    = UPD_PHT_ADDR_LSB + PHT_AW;

   // First fetch address out of reset
   localparam logic [PC_W-1:0] RESET_PC = 32'h0000_1000;

endpackage

`default_nettype wire
